/* id_pkg.sv */
// shared widths, types and encodings for the decode stage, imported by every design file
package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int GPR_NUM     = 32;

  typedef logic [XLEN-1:0]        gpr_data_t;
  typedef logic [XLEN-1:0]        pc_t;
  typedef logic [XLEN-1:0]        imm_t;
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [2:0]             br_func_t;

  localparam inst_t INST_NOP = 32'h0000_0013; // addi x0, x0, 0

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // branch funct3
  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

  typedef enum logic [2:0] {
    KIND_ALU,     // op-imm, op, lui, auipc
    KIND_LOAD,
    KIND_STORE,
    KIND_BRANCH,
    KIND_JAL,
    KIND_JALR,
    KIND_INVALID
  } dec_kind_e;

endpackage

/* dec_if.sv */
// decoded instruction fields, driven by the decoder and read by operand and branch logic
`timescale 1ns/1ps

interface dec_if;
  import id_pkg::*;

  gpr_addr_t rs1;
  gpr_addr_t rs2;
  gpr_addr_t rd;       // zero when nothing is written
  imm_t      imm;
  dec_kind_e kind;
  br_func_t  br_func;
  logic      gpr_wen;

  modport decoder (
    output rs1, rs2, rd, imm, kind, br_func, gpr_wen
  );

  modport operand_side (
    input rs1, rs2
  );

  modport branch_side (
    input imm, kind, br_func
  );

endinterface

/* ds_latch.sv */
// decode stage pipeline register, holds valid flag, instruction and pc with the fetch handshake
`timescale 1ns/1ps

module ds_latch (
  input  logic          i_clk,
  input  logic          i_arst_n,
  input  logic          i_fs_to_ds_valid,
  input  id_pkg::inst_t i_fs_inst,
  input  id_pkg::pc_t   i_fs_pc,
  input  logic          i_es_allowin,
  input  logic          i_load_stall,
  input  logic          i_take,
  output logic          o_ds_allowin,
  output logic          o_ds_to_es_valid,
  output id_pkg::inst_t o_ds_inst,
  output id_pkg::pc_t   o_ds_pc,
  output logic          o_br_taken
);
  import id_pkg::*;

  logic ds_valid;
  logic ds_ready_go;

  assign ds_ready_go      = ~i_load_stall;
  assign o_ds_allowin     = ~ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = ds_valid & ds_ready_go;
  assign o_br_taken       = i_take & o_ds_to_es_valid; // redirect only as the inst leaves

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid; // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ds_inst <= INST_NOP;
      o_ds_pc   <= '0;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_ds_inst <= i_fs_inst;
      o_ds_pc   <= i_fs_pc;
    end
  end

endmodule

/* inst_decoder.sv */
// combinational decode of the held instruction into register indices, immediate and kind
`timescale 1ns/1ps

module inst_decoder (
  input  id_pkg::inst_t i_inst,
  dec_if.decoder        dec
);
  import id_pkg::*;

  logic [6:0] opcode;
  imm_t       imm_i;
  imm_t       imm_s;
  imm_t       imm_b;
  imm_t       imm_u;
  imm_t       imm_j;

  assign opcode = i_inst[6:0];

  // sign-extended immediates, one per format
  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  assign dec.rs1     = i_inst[19:15];
  assign dec.rs2     = i_inst[24:20];
  assign dec.br_func = i_inst[14:12];

  always_comb begin
    dec.rd      = i_inst[11:7];
    dec.imm     = '0;
    dec.kind    = KIND_INVALID;
    dec.gpr_wen = 1'b1;
    case (opcode)
      OPC_OP_IMM: begin
        dec.kind = KIND_ALU;
        dec.imm  = imm_i;
      end
      OPC_OP:     dec.kind = KIND_ALU; // register-register, no imm
      OPC_LUI, OPC_AUIPC: begin
        dec.kind = KIND_ALU;
        dec.imm  = imm_u;
      end
      OPC_LOAD: begin
        dec.kind = KIND_LOAD;
        dec.imm  = imm_i;
      end
      OPC_STORE: begin
        dec.kind    = KIND_STORE;
        dec.imm     = imm_s;
        dec.rd      = '0;
        dec.gpr_wen = 1'b0;
      end
      OPC_BRANCH: begin
        dec.kind    = KIND_BRANCH;
        dec.imm     = imm_b;
        dec.rd      = '0;
        dec.gpr_wen = 1'b0;
      end
      OPC_JAL: begin
        dec.kind = KIND_JAL;
        dec.imm  = imm_j;
      end
      OPC_JALR: begin
        dec.kind = KIND_JALR;
        dec.imm  = imm_i;
      end
      default: begin
        dec.rd      = '0; // unknown opcode writes nothing
        dec.gpr_wen = 1'b0;
      end
    endcase
  end

endmodule

/* gpr_file.sv */
// general register file, two combinational reads and one write at the clock edge
`timescale 1ns/1ps

module gpr_file (
  input  logic              i_clk,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  input  logic              i_wen,
  input  id_pkg::gpr_addr_t i_waddr,
  input  id_pkg::gpr_data_t i_wdata,
  output id_pkg::gpr_data_t o_rdata1,
  output id_pkg::gpr_data_t o_rdata2
);
  import id_pkg::*;

  gpr_data_t regs [GPR_NUM];

  // x0 is never written
  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 reads as zero, a same-cycle write comes in through the wb bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* operand_bypass.sv */
// operand forwarding from execute, memory and write-back, plus load-use stall detection
`timescale 1ns/1ps

module operand_bypass (
  dec_if.operand_side       dec,
  input  id_pkg::gpr_data_t i_rdata1,
  input  id_pkg::gpr_data_t i_rdata2,
  input  id_pkg::gpr_addr_t i_es_gpr_rd,
  input  id_pkg::gpr_data_t i_es_gpr_result,
  input  id_pkg::gpr_addr_t i_ms_gpr_rd,
  input  id_pkg::gpr_data_t i_ms_gpr_result,
  input  id_pkg::gpr_addr_t i_ws_gpr_rd,
  input  id_pkg::gpr_data_t i_ws_gpr_result,
  input  logic              i_es_load_sel,
  output id_pkg::gpr_data_t o_rs1data,
  output id_pkg::gpr_data_t o_rs2data,
  output logic              o_load_stall
);
  import id_pkg::*;

  // youngest producer wins, rd of zero never forwards
  function automatic gpr_data_t fwd_sel(gpr_addr_t rs, gpr_data_t rf_data);
    if (i_es_gpr_rd != '0 && rs == i_es_gpr_rd) return i_es_gpr_result;
    if (i_ms_gpr_rd != '0 && rs == i_ms_gpr_rd) return i_ms_gpr_result;
    if (i_ws_gpr_rd != '0 && rs == i_ws_gpr_rd) return i_ws_gpr_result;
    return rf_data;
  endfunction

  assign o_rs1data = fwd_sel(dec.rs1, i_rdata1);
  assign o_rs2data = fwd_sel(dec.rs2, i_rdata2);

  // load data not ready until the load reaches mem
  assign o_load_stall = i_es_load_sel && (i_es_gpr_rd != '0) &&
                        ((i_es_gpr_rd == dec.rs1) || (i_es_gpr_rd == dec.rs2));

endmodule

/* branch_unit.sv */
// branch and jump resolution, target address and link value for the decode stage
`timescale 1ns/1ps

module branch_unit (
  dec_if.branch_side        dec,
  input  id_pkg::pc_t       i_pc,
  input  id_pkg::gpr_data_t i_rs1data,
  input  id_pkg::gpr_data_t i_rs2data,
  output logic              o_take,
  output id_pkg::pc_t       o_target,
  output id_pkg::gpr_data_t o_link
);
  import id_pkg::*;

  logic br_cond;
  logic is_jump;
  logic eq;
  logic lt_s;
  logic lt_u;
  pc_t  jalr_sum;

  assign eq   = (i_rs1data == i_rs2data);
  assign lt_s = ($signed(i_rs1data) < $signed(i_rs2data));
  assign lt_u = (i_rs1data < i_rs2data);

  always_comb begin
    case (dec.br_func)
      BR_BEQ:  br_cond = eq;
      BR_BNE:  br_cond = ~eq;
      BR_BLT:  br_cond = lt_s;
      BR_BGE:  br_cond = ~lt_s;
      BR_BLTU: br_cond = lt_u;
      BR_BGEU: br_cond = ~lt_u;
      default: br_cond = 1'b0; // funct3 010/011 not a branch
    endcase
  end

  assign is_jump  = (dec.kind == KIND_JAL) || (dec.kind == KIND_JALR);
  assign o_take   = is_jump || ((dec.kind == KIND_BRANCH) && br_cond);
  assign jalr_sum = i_rs1data + dec.imm;
  assign o_target = (dec.kind == KIND_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + dec.imm;

  // jumps hand the return address to execute in the rs2 slot
  assign o_link   = is_jump ? i_pc + 64'd4 : i_rs2data;

endmodule

/* id_stage.sv */
// decode stage top, connects latch, decoder, register file, bypass and branch unit
`timescale 1ns/1ps

module id_stage (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::pc_t       i_fs_pc,
  input  logic              i_es_allowin,
  input  logic              i_es_load_sel,
  input  id_pkg::gpr_addr_t i_es_gpr_rd,
  input  id_pkg::gpr_addr_t i_ms_gpr_rd,
  input  id_pkg::gpr_addr_t i_ws_gpr_rd,
  input  id_pkg::gpr_data_t i_es_gpr_result,
  input  id_pkg::gpr_data_t i_ms_gpr_result,
  input  id_pkg::gpr_data_t i_ws_gpr_result,
  input  logic              i_ws_gpr_wen,
  input  id_pkg::gpr_addr_t i_ws_gpr_waddr,
  input  id_pkg::gpr_data_t i_ws_gpr_wdata,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::gpr_data_t o_ds_rs1data,
  output id_pkg::gpr_data_t o_ds_rs2data,
  output id_pkg::imm_t      o_ds_imm,
  output id_pkg::pc_t       o_ds_pc,
  output id_pkg::gpr_addr_t o_ds_rd,
  output logic              o_ds_gpr_wen,
  output logic              o_ds_load_sel,
  output logic              o_ds_invalid,
  output logic              o_br_taken,
  output id_pkg::pc_t       o_br_target
);
  import id_pkg::*;

  inst_t     ds_inst;
  gpr_data_t rf_rdata1;
  gpr_data_t rf_rdata2;
  gpr_data_t fwd_rs2data; // before the link mux
  logic      load_stall;
  logic      br_take;

  dec_if dec ();

  assign o_ds_imm      = dec.imm;
  assign o_ds_rd       = dec.rd;
  assign o_ds_gpr_wen  = dec.gpr_wen;
  assign o_ds_load_sel = (dec.kind == KIND_LOAD);
  assign o_ds_invalid  = (dec.kind == KIND_INVALID);

  ds_latch u_latch (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_fs_to_ds_valid(i_fs_to_ds_valid), .i_fs_inst(i_fs_inst), .i_fs_pc(i_fs_pc),
    .i_es_allowin(i_es_allowin), .i_load_stall(load_stall), .i_take(br_take),
    .o_ds_allowin(o_ds_allowin), .o_ds_to_es_valid(o_ds_to_es_valid),
    .o_ds_inst(ds_inst), .o_ds_pc(o_ds_pc), .o_br_taken(o_br_taken)
  );

  inst_decoder u_decoder (.i_inst(ds_inst), .dec(dec.decoder));

  gpr_file u_gprs (
    .i_clk(i_clk), .i_raddr1(dec.rs1), .i_raddr2(dec.rs2),
    .i_wen(i_ws_gpr_wen), .i_waddr(i_ws_gpr_waddr), .i_wdata(i_ws_gpr_wdata),
    .o_rdata1(rf_rdata1), .o_rdata2(rf_rdata2)
  );

  operand_bypass u_bypass (
    .dec(dec.operand_side), .i_rdata1(rf_rdata1), .i_rdata2(rf_rdata2),
    .i_es_gpr_rd(i_es_gpr_rd), .i_es_gpr_result(i_es_gpr_result),
    .i_ms_gpr_rd(i_ms_gpr_rd), .i_ms_gpr_result(i_ms_gpr_result),
    .i_ws_gpr_rd(i_ws_gpr_rd), .i_ws_gpr_result(i_ws_gpr_result),
    .i_es_load_sel(i_es_load_sel),
    .o_rs1data(o_ds_rs1data), .o_rs2data(fwd_rs2data), .o_load_stall(load_stall)
  );

  branch_unit u_bru (
    .dec(dec.branch_side), .i_pc(o_ds_pc),
    .i_rs1data(o_ds_rs1data), .i_rs2data(fwd_rs2data),
    .o_take(br_take), .o_target(o_br_target), .o_link(o_ds_rs2data)
  );

endmodule

/* id_stage_asserts.sv */
// handshake assertions attached to id_stage with bind and watched by the testbench
`timescale 1ns/1ps

module id_stage_asserts (
  input logic              i_clk,
  input logic              i_arst_n,
  input logic              i_es_allowin,
  input logic              i_valid,
  input logic              i_br_taken,
  input id_pkg::gpr_data_t i_rs1data,
  input id_pkg::gpr_data_t i_rs2data,
  input id_pkg::imm_t      i_imm,
  input id_pkg::pc_t       i_pc,
  input id_pkg::gpr_addr_t i_rd,
  input id_pkg::pc_t       i_br_target
);

  int unsigned fail_count = 0; // failed assertions so far

  // one edge into reset the valid flag is cleared
  a_no_valid_in_reset: assert property (@(posedge i_clk) !i_arst_n |=> !i_valid)
    else begin
      $error("valid to execute raised during reset");
      fail_count++;
    end

  a_taken_needs_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_br_taken |-> i_valid)
    else begin
      $error("branch taken without a valid instruction");
      fail_count++;
    end

  a_hold_when_blocked: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_valid && !i_es_allowin) |=> (i_valid && $stable(i_rs1data) && $stable(i_rs2data)
      && $stable(i_imm) && $stable(i_pc) && $stable(i_rd) && $stable(i_br_target)))
    else begin
      $error("outputs changed while execute held off the stage");
      fail_count++;
    end

endmodule

bind id_stage id_stage_asserts u_asserts (
  .i_clk(i_clk), .i_arst_n(i_arst_n), .i_es_allowin(i_es_allowin),
  .i_valid(o_ds_to_es_valid), .i_br_taken(o_br_taken),
  .i_rs1data(o_ds_rs1data), .i_rs2data(o_ds_rs2data), .i_imm(o_ds_imm),
  .i_pc(o_ds_pc), .i_rd(o_ds_rd), .i_br_target(o_br_target)
);

/* tb_id_stage.sv */
// drives the decode stage from id_stim.txt and checks every output of the stage
`timescale 1ns/1ps

module tb_id_stage;
  import id_pkg::*;

  localparam int CLK_PERIOD = 40;

  logic      i_clk, i_arst_n, i_fs_to_ds_valid, i_es_allowin, i_es_load_sel, i_ws_gpr_wen;
  inst_t     i_fs_inst;
  pc_t       i_fs_pc, o_ds_pc, o_br_target;
  gpr_addr_t i_es_gpr_rd, i_ms_gpr_rd, i_ws_gpr_rd, i_ws_gpr_waddr, o_ds_rd;
  gpr_data_t i_es_gpr_result, i_ms_gpr_result, i_ws_gpr_result, i_ws_gpr_wdata;
  gpr_data_t o_ds_rs1data, o_ds_rs2data;
  imm_t      o_ds_imm;
  logic      o_ds_allowin, o_ds_to_es_valid, o_ds_gpr_wen, o_ds_load_sel;
  logic      o_ds_invalid, o_br_taken;

  string rows [$];   // non-comment lines of the stim file
  int    seed;
  bit    loaded;

  id_stage dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_data(gpr_data_t act, gpr_data_t exp, string what);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_pc(pc_t act, pc_t exp, string what);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_reg(gpr_addr_t act, gpr_addr_t exp, string what);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s: got x%0d, expected x%0d", $time, what, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(logic act, logic exp, string what);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, what, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic load_rows();
    int    fd;
    string line;
    fd = $fopen("id_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open id_stim.txt for reading");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
        rows.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  // preload one register through the write-back port
  task automatic write_reg(string args);
    gpr_addr_t addr;
    gpr_data_t data;
    int        n;
    n = $sscanf(args, "%h %h", addr, data);
    if (n != 2) begin
      $display("malformed register preload row: %s", args);
      stop_with_failure();
    end
    @(posedge i_clk);
    i_ws_gpr_wen   <= 1'b1;
    i_ws_gpr_waddr <= addr;
    i_ws_gpr_wdata <= data;
    @(posedge i_clk);
    i_ws_gpr_wen   <= 1'b0;
  endtask

  task automatic run_inst(string args);
    inst_t     inst;
    pc_t       pc, tgt;
    gpr_addr_t es_rd, ms_rd, ws_rd, e_rd;
    gpr_data_t es_res, ms_res, ws_res, e_rs1, e_rs2;
    imm_t      e_imm;
    bit        e_wen, e_load, e_inv, e_taken;
    int        hold;
    int        n;
    int        i;
    int        r;
    bit        sent;
    n = $sscanf(args, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                inst, pc, es_rd, es_res, ms_rd, ms_res, ws_rd, ws_res, hold,
                e_rs1, e_rs2, e_imm, e_rd, e_wen, e_load, e_inv, e_taken, tgt);
    if (n != 18) begin
      $display("malformed instruction row: %s", args);
      stop_with_failure();
    end
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= inst;
    i_fs_pc          <= pc;
    i_es_gpr_rd      <= es_rd;
    i_es_gpr_result  <= es_res;
    i_ms_gpr_rd      <= ms_rd;
    i_ms_gpr_result  <= ms_res;
    i_ws_gpr_rd      <= ws_rd;
    i_ws_gpr_result  <= ws_res;
    i_es_load_sel    <= (hold > 0); // load in execute for the hold cycles
    @(negedge i_clk);
    check_flag(o_ds_allowin, 1'b1, "allowin while stage empty");
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    for (i = 0; i < hold; i++) begin
      @(negedge i_clk);
      check_flag(o_ds_to_es_valid, 1'b0, "valid during load-use stall");
      @(posedge i_clk);
      if (i == hold - 1) i_es_load_sel <= 1'b0;
    end
    sent = 1'b0;
    while (!sent) begin
      @(negedge i_clk);
      if (o_ds_to_es_valid) begin
        check_data(o_ds_rs1data, e_rs1, "rs1 operand");
        check_data(o_ds_rs2data, e_rs2, "rs2 operand or link");
        check_data(o_ds_imm, e_imm, "immediate");
        check_pc(o_ds_pc, pc, "instruction pc");
        check_pc(o_br_target, tgt, "branch target");
        check_reg(o_ds_rd, e_rd, "destination register");
        check_flag(o_ds_gpr_wen, e_wen, "gpr write enable");
        check_flag(o_ds_load_sel, e_load, "load flag");
        check_flag(o_ds_invalid, e_inv, "invalid flag");
        check_flag(o_br_taken, e_taken, "branch taken");
        check_flag(o_ds_allowin, i_es_allowin, "allowin under back-pressure");
        sent = i_es_allowin;
      end
      @(posedge i_clk);
      r = $random(seed);
      i_es_allowin <= r[0];
    end
  endtask

  // run time limit scales with the number of rows
  initial begin
    wait (loaded);
    #(rows.size() * 50 * CLK_PERIOD);
    $display("watchdog timeout, the stimulus rows did not complete in time");
    stop_with_failure();
  end

  // a failed assertion in the bound checker ends the run as well
  initial begin
    wait (dut.u_asserts.fail_count != 0);
    $display("an assertion on the decode stage outputs failed");
    stop_with_failure();
  end

  initial begin
    seed             = 56;
    i_arst_n         = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = INST_NOP;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_es_load_sel    = 1'b0;
    i_es_gpr_rd      = '0;
    i_ms_gpr_rd      = '0;
    i_ws_gpr_rd      = '0;
    i_es_gpr_result  = '0;
    i_ms_gpr_result  = '0;
    i_ws_gpr_result  = '0;
    i_ws_gpr_wen     = 1'b0;
    i_ws_gpr_waddr   = '0;
    i_ws_gpr_wdata   = '0;
    load_rows();
    loaded = 1'b1;
    repeat (10) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    check_flag(o_ds_to_es_valid, 1'b0, "valid after reset");
    check_flag(o_br_taken, 1'b0, "branch taken after reset");
    check_flag(o_ds_allowin, 1'b1, "allowin after reset");
    foreach (rows[k]) begin
      case (rows[k].getc(0))
        "W": write_reg(rows[k].substr(1, rows[k].len() - 1));
        "I": run_inst(rows[k].substr(1, rows[k].len() - 1));
        default: begin
          $display("unknown row type in id_stim.txt: %s", rows[k]);
          stop_with_failure();
        end
      endcase
    end
    if (rows.size() > 0 && dut.u_asserts.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1, "no stimulus rows were run or an assertion failed");
    end
  end

endmodule

/* id_stim.txt */
# W rows: reg data | I rows: inst pc es_rd es_res ms_rd ms_res ws_rd ws_res hold, then
# expected rs1 rs2 imm rd wen load invalid taken target, all fields in hex
W 1 123
W 2 456
W 3 ffffffffffffff80
W 4 10
W 5 2000
I 00208333 100 0 0 0 0 0 0 0 123 456 0 6 1 0 0 0 100
I fe000393 104 0 0 0 0 0 0 0 0 0 ffffffffffffffe0 7 1 0 0 0 e4
I 00208433 108 1 aaa 1 bbb 1 ccc 0 aaa 456 0 8 1 0 0 0 108
I 00208433 10c 0 aaa 1 bbb 2 ddd 0 bbb ddd 0 8 1 0 0 0 10c
I 0040b483 110 1 777 0 0 0 0 3 777 10 4 9 1 1 0 0 114
I 00220533 114 2 999 0 0 0 0 2 10 999 0 a 1 0 0 0 114
I 00108863 200 0 0 0 0 0 0 0 123 123 10 0 0 0 0 1 210
I fe209ce3 204 0 0 0 0 0 0 0 123 456 fffffffffffffff8 0 0 0 0 1 1fc
I 0011c863 208 0 0 0 0 0 0 0 ffffffffffffff80 123 10 0 0 0 0 1 218
I 0011d863 20c 0 0 0 0 0 0 0 ffffffffffffff80 123 10 0 0 0 0 0 21c
I 0011e863 210 0 0 0 0 0 0 0 ffffffffffffff80 123 10 0 0 0 0 0 220
I 0011f863 214 0 0 0 0 0 0 0 ffffffffffffff80 123 10 0 0 0 0 1 224
I 040005ef 300 0 0 0 0 0 0 0 0 304 40 b 1 0 0 1 340
I 00328667 304 0 0 0 0 0 0 0 2000 308 3 c 1 0 0 1 2002
I 002086ff 400 0 0 0 0 0 0 0 123 456 0 0 0 0 1 0 400

/* files.f */
id_pkg.sv
dec_if.sv
ds_latch.sv
inst_decoder.sv
gpr_file.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
id_stage_asserts.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - id_pkg.sv
  - dec_if.sv
  - ds_latch.sv
  - inst_decoder.sv
  - gpr_file.sv
  - operand_bypass.sv
  - branch_unit.sv
  - id_stage.sv
  - target: simulation
    files:
      - id_stage_asserts.sv
      - tb_id_stage.sv
